//--- rtl/arb_macros.svh
// sizes are global to the build; the requester count must be a power of two of at least 2
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// number of requesters merged onto the single output stream
// the round-robin pointer wraps at this count, and every vector
// in the design carries one bit per requester
`define ARB_NUM_REQ 4

// payload width of one beat, without the last flag
// the output adds the last flag and the source index on top of this
`define ARB_DATA_W 16

`endif

//--- rtl/arb_pkg.sv
// types only; widths follow arb_macros.svh and a beat carries no byte enables or error flags
`default_nettype none

`include "arb_macros.svh"

package arb_pkg;

  // one bit per requester, used for valid, grant, hold and pop
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // binary index of a requester
  typedef logic [$clog2(`ARB_NUM_REQ)-1:0] req_idx_t;

  // payload of a single beat
  typedef logic [`ARB_DATA_W-1:0] data_t;

  // a beat as presented by a requester, last marks the end of the packet
  typedef struct packed {
    data_t data;
    logic  last;
  } beat_t;

  // a beat on the merged output, tagged with the requester it came from
  typedef struct packed {
    beat_t    beat;
    req_idx_t src;
  } out_beat_t;

endpackage : arb_pkg

`default_nettype wire

//--- rtl/rr_arbiter.sv
// grant is combinational from req and the pointer, so req must be stable within the cycle
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module rr_arbiter
  import arb_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  req_vec_t req,
  input  logic     update_en,
  output req_vec_t grant
);

  // requester that currently has the highest priority
  req_idx_t ptr;

  // index of the winning requester, only meaningful when grant is non-zero
  req_idx_t win_idx;

  // scan the request vector starting at the pointer and wrapping around
  // the first requesting bit wins and gets a one-hot grant
  always_comb begin
    int   scan;
    logic found;
    grant   = '0;
    win_idx = ptr;
    found   = 1'b0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      scan = (int'(ptr) + i) % `ARB_NUM_REQ;
      if (!found && req[scan]) begin
        found       = 1'b1;
        grant[scan] = 1'b1;
        win_idx     = req_idx_t'(scan);
      end
    end
  end

  // the pointer moves to one past the winner so the winner gets lowest
  // priority next time round
  // the requester count is a power of two, so one past the top requester
  // wraps back to requester 0 on its own
  // a held grant keeps update_en low, which freezes the pointer for the
  // whole packet and keeps the rotation at packet granularity
  always_ff @(posedge clk) begin
    if (rst) begin
      // requester 0 has priority first after reset
      ptr <= '0;
    end else if (update_en && (|grant)) begin
      ptr <= win_idx + req_idx_t'(1);
    end
  end

  // never more than one winner, and only a requester that asks can win
  // the beat mux and the grant holder both rely on a one-hot grant
  grant_onehot_subset_a : assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~req) == '0)
  ) else $error("rr_arbiter: grant %b is not one-hot or not within req %b", grant, req);

endmodule : rr_arbiter

`default_nettype wire

//--- rtl/arb_grant_hold.sv
// expects a one-hot or zero grant from the arbiter; a held grant ignores all other requests
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module arb_grant_hold
  import arb_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  req_vec_t grant_hold,
  input  req_vec_t grant_from_arb,
  output logic     update_en,
  output req_vec_t grant
);

  // requester whose grant is locked for the rest of its packet
  req_vec_t hold;
  req_vec_t hold_next;

  // a granted requester that asks to hold keeps its grant next cycle
  // a hold bit on a requester that is not granted does nothing
  assign hold_next = grant & grant_hold;

  // the stored grant wins over the arbiter while any hold bit is set
  assign grant = (|hold) ? hold : grant_from_arb;

  // the arbiter only rotates its priority when nothing is held
  assign update_en = ~(|hold);

  // captured every cycle, so the hold drops one cycle after its bit falls
  always_ff @(posedge clk) begin
    if (rst) begin
      hold <= '0;
    end else begin
      hold <= hold_next;
    end
  end

  // a grant that is asked to hold must still be the grant a cycle later,
  // whatever the arbiter does with its own output meanwhile
  grant_held_a : assert property (
    @(posedge clk) disable iff (rst)
    (|(grant & grant_hold)) |=> (grant == $past(grant))
  ) else $error("arb_grant_hold: held grant changed to %b", grant);

endmodule : arb_grant_hold

`default_nettype wire

//--- rtl/beat_mux.sv
// no back-pressure on the output; every pop produces an output beat one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module beat_mux
  import arb_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  req_vec_t                     grant,
  input  req_vec_t                     in_valid,
  input  beat_t [`ARB_NUM_REQ-1:0]     in_beat,
  output req_vec_t                     pop,
  output logic                         out_valid,
  output out_beat_t                    out_beat
);

  // binary index of the granted requester
  req_idx_t sel_idx;

  // encode the one-hot grant into an index
  // a zero grant leaves index 0, which is harmless because pop is zero then
  always_comb begin
    sel_idx = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (grant[i]) begin
        sel_idx = req_idx_t'(i);
      end
    end
  end

  // a held grant can point at a source that has dropped valid,
  // so only a valid granted source is popped
  assign pop = grant & in_valid;

  // the output is valid in the cycle right after a pop
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= |pop;
    end
  end

  // payload is captured every cycle and only looked at with out_valid
  always_ff @(posedge clk) begin
    out_beat.beat <= in_beat[sel_idx];
    out_beat.src  <= sel_idx;
  end

  // two pops in one cycle would take two beats for one output slot
  pop_onehot_a : assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(pop)
  ) else $error("beat_mux: pop %b is not one-hot", pop);

endmodule : beat_mux

`default_nettype wire

//--- rtl/packet_arbiter_top.sv
// sources hold in_beat stable until popped; a source that stalls mid-packet blocks all others
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module packet_arbiter_top
  import arb_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  req_vec_t                     in_valid,
  input  beat_t [`ARB_NUM_REQ-1:0]     in_beat,
  output req_vec_t                     pop,
  output logic                         out_valid,
  output out_beat_t                    out_beat
);

  req_vec_t grant_from_arb;
  req_vec_t grant;
  req_vec_t grant_hold;
  logic     update_en;

  // a requester stays held until a valid last beat is presented
  // a source that has no beat up keeps its hold, so a packet paused
  // in the middle is not broken up by other sources
  always_comb begin
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      grant_hold[i] = ~(in_valid[i] & in_beat[i].last);
    end
  end

  rr_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .req       (in_valid),
    .update_en (update_en),
    .grant     (grant_from_arb)
  );

  arb_grant_hold u_grant_hold (
    .clk            (clk),
    .rst            (rst),
    .grant_hold     (grant_hold),
    .grant_from_arb (grant_from_arb),
    .update_en      (update_en),
    .grant          (grant)
  );

  // the beat popped in a cycle shows up on the output in the next one
  beat_mux u_beat_mux (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .pop       (pop),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

endmodule : packet_arbiter_top

`default_nettype wire

//--- verification/packet_arbiter_tb.sv
// reads verification/packet_arbiter_stimulus.txt relative to the run directory; 32 beats per source at most
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module packet_arbiter_tb
  import arb_pkg::*;
();

  localparam int NUM_REQ   = `ARB_NUM_REQ;
  localparam int MAX_BEATS = 32;
  localparam int TIMEOUT   = 2000;

  logic                clk;
  logic                rst;
  req_vec_t            in_valid;
  beat_t [NUM_REQ-1:0] in_beat;
  req_vec_t            pop;
  logic                out_valid;
  out_beat_t           out_beat;

  // beats of every source in file order, with the idle cycles before each one
  beat_t stim_beat [NUM_REQ][MAX_BEATS];
  int    stim_gap  [NUM_REQ][MAX_BEATS];
  int    stim_cnt  [NUM_REQ];
  // next beat to present, next beat expected on the output, idle cycles still to go
  int    drv_head  [NUM_REQ];
  int    out_head  [NUM_REQ];
  int    idle_left [NUM_REQ];

  // reference state of the packet order on the input side
  logic  locked;
  int    lock_src;
  int    next_src;
  // what was popped on the previous cycle, due on the output now
  logic  prev_popped;
  int    prev_src;
  // packet currently streaming out, used for the interleave check
  logic  out_in_pkt;
  int    out_pkt_src;

  int    seed = 32'h3c0d;
  int    errors;
  int    beats_seen;
  int    cycles;

  packet_arbiter_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .pop       (pop),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

  always #2 clk = ~clk;

  // parses the data file, adding a random idle time before some first beats
  task automatic load_stimulus();
    int    fd;
    int    n;
    int    s;
    int    d;
    int    l;
    int    g;
    int    rnd;
    string line;
    fd = $fopen("verification/packet_arbiter_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %h %d %d", s, d, l, g);
      if (n != 4 || s < 0 || s >= NUM_REQ || stim_cnt[s] >= MAX_BEATS) begin
        $display("unreadable or surplus stimulus line: %s", line);
        errors++;
        continue;
      end
      rnd = $random(seed);
      // only a first beat that already has a gap gets stretched, so back to back
      // packets in the file stay back to back
      if (g > 0 && (stim_cnt[s] == 0 || stim_beat[s][stim_cnt[s]-1].last)) begin
        g = g + (rnd & 3);
      end
      stim_beat[s][stim_cnt[s]].data = data_t'(d);
      stim_beat[s][stim_cnt[s]].last = l[0];
      stim_gap[s][stim_cnt[s]]       = g;
      stim_cnt[s]++;
    end
    $fclose(fd);
  endtask

  // an open packet keeps its source; otherwise the first valid source at or
  // after the one following the previous packet's source wins
  function automatic req_vec_t expected_pop(req_vec_t valid);
    req_vec_t e;
    logic     found;
    int       k;
    e     = '0;
    found = 1'b0;
    if (locked) begin
      e[lock_src] = valid[lock_src];
    end else begin
      for (int i = 0; i < NUM_REQ; i++) begin
        k = (next_src + i) % NUM_REQ;
        if (!found && valid[k]) begin
          e[k]  = 1'b1;
          found = 1'b1;
        end
      end
    end
    return e;
  endfunction

  function automatic logic all_drained();
    logic d;
    d = 1'b1;
    for (int s = 0; s < NUM_REQ; s++) begin
      if (out_head[s] < stim_cnt[s]) begin
        d = 1'b0;
      end
    end
    return d;
  endfunction

  // compares one output beat with the next file beat of the source popped last cycle
  task automatic check_output();
    int    s;
    beat_t exp;
    s = int'(out_beat.src);
    beats_seen++;
    if (out_beat.src !== req_idx_t'(prev_src)) begin
      $display("Mismatch at %0t: out_beat.src expected %0d got %0d", $time, prev_src, s);
      errors++;
    end
    if (out_in_pkt && s != out_pkt_src) begin
      $display("packet from source %0d interleaved with source %0d at %0t", out_pkt_src, s, $time);
      errors++;
    end
    if (out_head[s] >= stim_cnt[s]) begin
      $display("source %0d sent more beats than its stimulus holds at %0t", s, $time);
      errors++;
    end else begin
      exp = stim_beat[s][out_head[s]];
      if (out_beat.beat.data !== exp.data) begin
        $display("Mismatch at %0t: out_beat.data expected %h got %h", $time, exp.data,
                 out_beat.beat.data);
        errors++;
      end
      if (out_beat.beat.last !== exp.last) begin
        $display("Mismatch at %0t: out_beat.last expected %b got %b", $time, exp.last,
                 out_beat.beat.last);
        errors++;
      end
      out_head[s]++;
    end
    out_in_pkt  = !out_beat.beat.last;
    out_pkt_src = s;
  endtask

  // outputs are sampled at the edge before any register moves, inputs change after it
  always @(posedge clk) begin
    req_vec_t exp_pop;
    if (rst) begin
      in_valid <= '0;
    end else begin
      if (out_valid !== prev_popped) begin
        $display("Mismatch at %0t: out_valid expected %b got %b", $time, prev_popped, out_valid);
        errors++;
      end
      if (out_valid === 1'b1) begin
        check_output();
      end
      exp_pop = expected_pop(in_valid);
      if (pop !== exp_pop) begin
        $display("Mismatch at %0t: pop expected %b got %b", $time, exp_pop, pop);
        errors++;
      end
      prev_popped = 1'b0;
      for (int s = 0; s < NUM_REQ; s++) begin
        if (pop[s] === 1'b1 && in_valid[s]) begin
          prev_popped = 1'b1;
          prev_src    = s;
          locked      = !in_beat[s].last;
          lock_src    = s;
          if (in_beat[s].last) begin
            next_src = (s + 1) % NUM_REQ;
          end
          drv_head[s]++;
          idle_left[s] = (drv_head[s] < stim_cnt[s]) ? stim_gap[s][drv_head[s]] : 0;
        end
      end
      // each source shows its current beat unless it is idling or out of beats
      for (int s = 0; s < NUM_REQ; s++) begin
        if (idle_left[s] > 0) begin
          idle_left[s]--;
          in_valid[s] <= 1'b0;
        end else if (drv_head[s] < stim_cnt[s]) begin
          in_valid[s] <= 1'b1;
          in_beat[s]  <= stim_beat[s][drv_head[s]];
        end else begin
          in_valid[s] <= 1'b0;
        end
      end
    end
  end

  initial begin
    clk         = 1'b0;
    rst        <= 1'b1;
    in_valid   <= '0;
    in_beat    <= '0;
    errors      = 0;
    beats_seen  = 0;
    cycles      = 0;
    locked      = 1'b0;
    lock_src    = 0;
    // requester 0 has priority first, as if the last packet came from the top source
    next_src    = 0;
    prev_popped = 1'b0;
    prev_src    = 0;
    out_in_pkt  = 1'b0;
    out_pkt_src = 0;
    for (int s = 0; s < NUM_REQ; s++) begin
      stim_cnt[s] = 0;
      drv_head[s] = 0;
      out_head[s] = 0;
    end
    load_stimulus();
    for (int s = 0; s < NUM_REQ; s++) begin
      idle_left[s] = (stim_cnt[s] > 0) ? stim_gap[s][0] : 0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    while (!all_drained() && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!all_drained()) begin
      $display("timeout: the output did not drain within %0d cycles", TIMEOUT);
      errors++;
    end
    // a few idle cycles catch any duplicated beat arriving late
    repeat (4) @(negedge clk);
    for (int s = 0; s < NUM_REQ; s++) begin
      if (out_head[s] != stim_cnt[s]) begin
        $display("source %0d: only %0d of %0d beats reached the output", s, out_head[s],
                 stim_cnt[s]);
        errors++;
      end
    end
    $display("errors: %0d  beats checked: %0d  cycles: %0d", errors, beats_seen, cycles);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : packet_arbiter_tb

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/arb_pkg.sv
rtl/rr_arbiter.sv
rtl/arb_grant_hold.sv
rtl/beat_mux.sv
rtl/packet_arbiter_top.sv
verification/packet_arbiter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the packet arbiter testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module packet_arbiter_tb \
  -f compile.f \
  -o sim_packet_arbiter

output=$(./obj_dir/sim_packet_arbiter)
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

//--- verification/packet_arbiter_stimulus.txt
# columns: source index, payload in hex, last flag, idle cycles before the beat
# beats are grouped per source in packet order; a gap inside a packet drops valid mid-packet
0 0001 0 2
0 0002 0 0
0 0003 1 0
0 0010 1 0
0 0011 1 0
0 0012 1 0
0 0020 0 4
0 0021 1 0
0 0030 1 0
1 1001 0 2
1 1002 1 0
1 1010 1 0
1 1011 1 0
1 1012 1 0
1 1020 0 0
1 1021 0 0
1 1022 0 0
1 1023 1 0
1 1030 1 3
2 2001 1 2
2 2010 1 0
2 2011 1 0
2 2020 0 0
2 2021 0 5
2 2022 1 0
2 2030 1 0
2 2031 1 0
2 2040 0 2
2 2041 1 3
3 3001 0 2
3 3002 0 0
3 3003 0 0
3 3004 1 0
3 3010 1 0
3 3011 1 0
3 3012 1 0
3 3020 0 0
3 3021 1 4
3 3030 1 0
3 3031 1 1
